/* Makefile */
VERILATOR ?= verilator
TOP ?= busDatapathTb
FILELIST ?= busDatapath.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "test failed" $(LOG); then exit 1; fi
	@grep -q "test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* busDatapath.f */
logic/busDatapathPkg.sv
logic/selectEncode.sv
logic/registerFile.sv
logic/specialRegisters.sv
logic/alu.sv
logic/memoryInterface.sv
logic/conFf.sv
logic/busMux.sv
logic/busDatapath.sv
testbench/busDatapathTb.sv

/* logic/alu.sv */
`timescale 1ns/100ps
module alu (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::wordT bus,
	input busDatapathPkg::loadEnT loadEn,
	input busDatapathPkg::aluOpT aluOp,
	output logic [2*busDatapathPkg::wordWidth-1:0] aluResult
);
	busDatapathPkg::wordT y;
	busDatapathPkg::wordT lowResult;
	logic [4:0] shamt;
	logic [2*busDatapathPkg::wordWidth-1:0] yTwice;
	logic [2*busDatapathPkg::wordWidth-1:0] product;
	logic [2*busDatapathPkg::wordWidth-1:0] rotLeft;
	logic [2*busDatapathPkg::wordWidth-1:0] rotRight;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			y <= '0;
		end else if (loadEn[busDatapathPkg::ldY]) begin
			y <= bus; // first operand, held over a step
		end
	end

	assign shamt = bus[4:0];
	assign yTwice = {y, y};
	assign rotLeft = yTwice << shamt; // rol result sits in the upper word
	assign rotRight = yTwice >> shamt;

	// sign-extend both to 64 bits so the low 64 of the product are the signed result
	assign product = {{32{y[31]}}, y} * {{32{bus[31]}}, bus};

	always_comb begin
		case (aluOp)
			busDatapathPkg::aluAdd: lowResult = y + bus;
			busDatapathPkg::aluSub: lowResult = y - bus;
			busDatapathPkg::aluAnd: lowResult = y & bus;
			busDatapathPkg::aluOr: lowResult = y | bus;
			busDatapathPkg::aluShr: lowResult = y >> shamt;
			busDatapathPkg::aluShra: lowResult = $signed(y) >>> shamt;
			busDatapathPkg::aluShl: lowResult = y << shamt;
			busDatapathPkg::aluRor: lowResult = rotRight[31:0];
			busDatapathPkg::aluRol: lowResult = rotLeft[63:32];
			busDatapathPkg::aluNeg: lowResult = -bus; // unary ops take the bus
			busDatapathPkg::aluNot: lowResult = ~bus;
			busDatapathPkg::aluIncPc: lowResult = bus + 32'd1;
			default: lowResult = '0;
		endcase
	end

	always_comb begin
		if (aluOp == busDatapathPkg::aluMul) begin
			aluResult = product;
		end else begin
			aluResult = {{32{lowResult[31]}}, lowResult};
		end
	end
endmodule

/* logic/busDatapath.sv */
`timescale 1ns/100ps
module busDatapath (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::busSelT busSel,
	input busDatapathPkg::loadEnT loadEn,
	input logic [busDatapathPkg::regCount-1:0] regLoad,
	input busDatapathPkg::aluOpT aluOp,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rin,
	input logic rout,
	input logic baOut,
	input logic mdRead,
	input logic readRam,
	input logic writeRam,
	input busDatapathPkg::wordT inPortData,
	output busDatapathPkg::wordT bus,
	output busDatapathPkg::wordT outPort,
	output logic conFlag,
	output busDatapathPkg::wordT pc,
	output busDatapathPkg::wordT ir,
	output busDatapathPkg::wordT mdr
);
	busDatapathPkg::regIndexT regIndex;
	logic regWrite;
	logic regRead;
	logic forceZero;
	busDatapathPkg::wordT cSignExt;
	busDatapathPkg::wordT regs [busDatapathPkg::regCount];
	busDatapathPkg::wordT regOut;
	busDatapathPkg::wordT hi;
	busDatapathPkg::wordT lo;
	busDatapathPkg::wordT zHigh;
	busDatapathPkg::wordT zLow;
	busDatapathPkg::wordT inPort;
	busDatapathPkg::addrT mar;
	logic [2*busDatapathPkg::wordWidth-1:0] aluResult;

	selectEncode uSelect (.ir(ir), .gra(gra), .grb(grb), .grc(grc), .rin(rin),
		.rout(rout), .baOut(baOut), .regIndex(regIndex), .regWrite(regWrite),
		.regRead(regRead), .forceZero(forceZero), .cSignExt(cSignExt));

	registerFile uRegs (.clk(clk), .rstN(rstN), .bus(bus), .regIndex(regIndex),
		.regWrite(regWrite), .forceZero(forceZero), .directIn(regLoad),
		.regs(regs), .regOut(regOut));

	specialRegisters uSpecial (.clk(clk), .rstN(rstN), .bus(bus),
		.aluResult(aluResult), .loadEn(loadEn), .inPortData(inPortData),
		.pc(pc), .ir(ir), .hi(hi), .lo(lo), .zHigh(zHigh), .zLow(zLow),
		.inPort(inPort), .outPort(outPort));

	alu uAlu (.clk(clk), .rstN(rstN), .bus(bus), .loadEn(loadEn), .aluOp(aluOp),
		.aluResult(aluResult));

	memoryInterface uMem (.clk(clk), .rstN(rstN), .bus(bus), .loadEn(loadEn),
		.mdRead(mdRead), .readRam(readRam), .writeRam(writeRam), .mdr(mdr), .mar(mar));

	conFf uCon (.clk(clk), .rstN(rstN), .bus(bus), .ir(ir), .loadEn(loadEn),
		.conFlag(conFlag));

	busMux uBus (.busSel(busSel), .regs(regs), .regOut(regOut), .regRead(regRead),
		.cSignExt(cSignExt), .hi(hi), .lo(lo), .zHigh(zHigh), .zLow(zLow), .pc(pc),
		.mdr(mdr), .inPort(inPort), .bus(bus));
endmodule

/* logic/busDatapathPkg.sv */
package busDatapathPkg;
	localparam int wordWidth = 32;
	localparam int regCount = 16;
	localparam int addrWidth = 9;
	localparam int memWords = 512;
	localparam int busSrcCount = 24;
	localparam int loadEnWidth = 16;
	localparam int aluOpWidth = 5;

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [3:0] regIndexT;
	typedef logic [addrWidth-1:0] addrT;
	typedef logic [busSrcCount-1:0] busSelT;
	typedef logic [loadEnWidth-1:0] loadEnT;
	typedef logic [aluOpWidth-1:0] aluOpT;

	// bus sources, r0..r15 occupy bits 0 to 15
	localparam int busSrcR0 = 0;
	localparam int busSrcR15 = 15;
	localparam int busSrcHi = 16;
	localparam int busSrcLo = 17;
	localparam int busSrcZHigh = 18;
	localparam int busSrcZLow = 19;
	localparam int busSrcPc = 20;
	localparam int busSrcMdr = 21;
	localparam int busSrcInPort = 22;
	localparam int busSrcC = 23; // sign-extended IR constant

	localparam int ldHi = 0;
	localparam int ldLo = 1;
	localparam int ldZ = 2;
	localparam int ldPc = 3;
	localparam int ldMdr = 4;
	localparam int ldIr = 5;
	localparam int ldMar = 6;
	localparam int ldY = 7;
	localparam int ldOutPort = 8;
	localparam int ldInPort = 9;
	localparam int ldCon = 10;

	localparam aluOpT aluAdd = 5'd0;
	localparam aluOpT aluSub = 5'd1;
	localparam aluOpT aluAnd = 5'd2;
	localparam aluOpT aluOr = 5'd3;
	localparam aluOpT aluShr = 5'd4;
	localparam aluOpT aluShra = 5'd5;
	localparam aluOpT aluShl = 5'd6;
	localparam aluOpT aluRor = 5'd7;
	localparam aluOpT aluRol = 5'd8;
	localparam aluOpT aluMul = 5'd9;
	localparam aluOpT aluNeg = 5'd10;
	localparam aluOpT aluNot = 5'd11;
	localparam aluOpT aluIncPc = 5'd12;
endpackage

/* logic/busMux.sv */
`timescale 1ns/100ps
module busMux (
	input busDatapathPkg::busSelT busSel,
	input busDatapathPkg::wordT regs [busDatapathPkg::regCount],
	input busDatapathPkg::wordT regOut,
	input logic regRead,
	input busDatapathPkg::wordT cSignExt,
	input busDatapathPkg::wordT hi,
	input busDatapathPkg::wordT lo,
	input busDatapathPkg::wordT zHigh,
	input busDatapathPkg::wordT zLow,
	input busDatapathPkg::wordT pc,
	input busDatapathPkg::wordT mdr,
	input busDatapathPkg::wordT inPort,
	output busDatapathPkg::wordT bus
);
	logic [4:0] srcIndex;
	logic srcValid;

	always_comb begin
		srcIndex = '0;
		srcValid = 1'b0;
		for (int i = 0; i < busDatapathPkg::busSrcCount; i++) begin
			if (busSel[i]) begin
				srcIndex = 5'(i);
				srcValid = 1'b1;
			end
		end
	end

	always_comb begin
		bus = '0; // idle bus reads zero
		if (regRead) begin
			bus = regOut; // IR-selected register wins
		end else if (srcValid) begin
			if (srcIndex <= 5'(busDatapathPkg::busSrcR15)) begin
				bus = regs[4'(srcIndex - 5'(busDatapathPkg::busSrcR0))];
			end else begin
				case (srcIndex)
					5'(busDatapathPkg::busSrcHi): bus = hi;
					5'(busDatapathPkg::busSrcLo): bus = lo;
					5'(busDatapathPkg::busSrcZHigh): bus = zHigh;
					5'(busDatapathPkg::busSrcZLow): bus = zLow;
					5'(busDatapathPkg::busSrcPc): bus = pc;
					5'(busDatapathPkg::busSrcMdr): bus = mdr;
					5'(busDatapathPkg::busSrcInPort): bus = inPort;
					5'(busDatapathPkg::busSrcC): bus = cSignExt;
					default: bus = '0;
				endcase
			end
		end
	end

	always_comb begin
		assert final ($onehot0(busSel) && !(regRead && (|busSel)))
			else $error("busMux: bus select not one-hot or clashes with regRead");
	end
endmodule

/* logic/conFf.sv */
`timescale 1ns/100ps
module conFf (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::wordT bus,
	input busDatapathPkg::wordT ir,
	input busDatapathPkg::loadEnT loadEn,
	output logic conFlag
);
	logic condMet;

	always_comb begin
		case (ir[20:19]) // c2 field
			2'b00: condMet = (bus == '0); // zero
			2'b01: condMet = (bus != '0); // nonzero
			2'b10: condMet = !bus[31]; // positive, sign clear
			default: condMet = bus[31]; // negative
		endcase
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			conFlag <= 1'b0;
		end else if (loadEn[busDatapathPkg::ldCon]) begin
			conFlag <= condMet;
		end
	end
endmodule

/* logic/memoryInterface.sv */
`timescale 1ns/100ps
module memoryInterface (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::wordT bus,
	input busDatapathPkg::loadEnT loadEn,
	input logic mdRead,
	input logic readRam,
	input logic writeRam,
	output busDatapathPkg::wordT mdr,
	output busDatapathPkg::addrT mar
);
	busDatapathPkg::wordT ram [busDatapathPkg::memWords];
	busDatapathPkg::wordT mdrIn;
	logic mdrLoad;

	// memory side only when the RAM is actually being read
	assign mdrIn = mdRead ? ram[mar] : bus;
	assign mdrLoad = loadEn[busDatapathPkg::ldMdr] && (readRam || !mdRead);

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			mar <= '0;
			mdr <= '0;
		end else begin
			if (loadEn[busDatapathPkg::ldMar]) begin
				mar <= bus[busDatapathPkg::addrWidth-1:0]; // word address
			end
			if (mdrLoad) begin
				mdr <= mdrIn;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (writeRam) begin
			ram[mar] <= mdr; // MDR must already hold the data
		end
	end

	assert property (@(posedge clk) disable iff (!rstN)
		!(readRam && writeRam))
		else $error("memoryInterface: readRam and writeRam both high");
endmodule

/* logic/registerFile.sv */
`timescale 1ns/100ps
module registerFile (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::wordT bus,
	input busDatapathPkg::regIndexT regIndex,
	input logic regWrite,
	input logic forceZero,
	input logic [busDatapathPkg::regCount-1:0] directIn,
	output busDatapathPkg::wordT regs [busDatapathPkg::regCount],
	output busDatapathPkg::wordT regOut
);
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < busDatapathPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < busDatapathPkg::regCount; i++) begin
				if (directIn[i]) begin
					regs[i] <= bus; // testbench preload path
				end
			end
			if (regWrite) begin
				regs[regIndex] <= bus; // Rin through the IR field
			end
		end
	end

	// r0 reads as zero only for address arithmetic (BAout)
	assign regOut = forceZero ? '0 : regs[regIndex];

	// both write paths on one edge would race for the same register
	assert property (@(posedge clk) disable iff (!rstN)
		!(regWrite && (|directIn)))
		else $error("registerFile: regWrite and directIn high together");
endmodule

/* logic/selectEncode.sv */
`timescale 1ns/100ps
module selectEncode (
	input busDatapathPkg::wordT ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rin,
	input logic rout,
	input logic baOut,
	output busDatapathPkg::regIndexT regIndex,
	output logic regWrite,
	output logic regRead,
	output logic forceZero,
	output busDatapathPkg::wordT cSignExt
);
	always_comb begin
		if (gra) begin
			regIndex = ir[26:23]; // ra field
		end else if (grb) begin
			regIndex = ir[22:19]; // rb field
		end else if (grc) begin
			regIndex = ir[18:15]; // rc field
		end else begin
			regIndex = '0;
		end
	end

	assign regWrite = rin;
	assign regRead = rout | baOut; // BAout is a read with r0 masked
	assign forceZero = baOut && (regIndex == '0);
	assign cSignExt = {{13{ir[18]}}, ir[18:0]}; // 19-bit constant

	always_comb begin
		assert final ($onehot0({gra, grb, grc}))
			else $error("selectEncode: more than one of gra/grb/grc set");
	end
endmodule

/* logic/specialRegisters.sv */
`timescale 1ns/100ps
module specialRegisters (
	input logic clk,
	input logic rstN,
	input busDatapathPkg::wordT bus,
	input logic [2*busDatapathPkg::wordWidth-1:0] aluResult,
	input busDatapathPkg::loadEnT loadEn,
	input busDatapathPkg::wordT inPortData,
	output busDatapathPkg::wordT pc,
	output busDatapathPkg::wordT ir,
	output busDatapathPkg::wordT hi,
	output busDatapathPkg::wordT lo,
	output busDatapathPkg::wordT zHigh,
	output busDatapathPkg::wordT zLow,
	output busDatapathPkg::wordT inPort,
	output busDatapathPkg::wordT outPort
);
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
			ir <= '0;
			hi <= '0;
			lo <= '0;
			zHigh <= '0;
			zLow <= '0;
			inPort <= '0;
			outPort <= '0;
		end else begin
			if (loadEn[busDatapathPkg::ldPc]) pc <= bus;
			if (loadEn[busDatapathPkg::ldIr]) ir <= bus;
			if (loadEn[busDatapathPkg::ldHi]) hi <= bus;
			if (loadEn[busDatapathPkg::ldLo]) lo <= bus;
			if (loadEn[busDatapathPkg::ldZ]) begin
				{zHigh, zLow} <= aluResult; // both halves in one step
			end
			if (loadEn[busDatapathPkg::ldInPort]) inPort <= inPortData; // external pins
			if (loadEn[busDatapathPkg::ldOutPort]) outPort <= bus;
		end
	end
endmodule

/* testbench/busDatapathTb.sv */
`timescale 1ns/100ps
module busDatapathTb;
	localparam int cycleLimit = 3000; // about six times the ~460 steps below

	logic clk;
	logic rstN;
	busDatapathPkg::busSelT busSel;
	busDatapathPkg::loadEnT loadEn;
	logic [15:0] regLoad;
	busDatapathPkg::aluOpT aluOp;
	logic gra, grb, grc, rin, rout, baOut;
	logic mdRead, readRam, writeRam;
	busDatapathPkg::wordT inPortData;
	busDatapathPkg::wordT bus, outPort, pc, ir, mdr;
	logic conFlag;

	// reference model state, always one step ahead of the DUT registers
	busDatapathPkg::wordT mRegs [16];
	busDatapathPkg::wordT mRam [busDatapathPkg::memWords];
	busDatapathPkg::wordT mHi, mLo, mPc, mIr, mY, mMdr, mInPort, mOutPort;
	logic [63:0] mZ;
	busDatapathPkg::addrT mMar;
	logic mCon;

	busDatapathPkg::wordT expBus, expPc, expIr, expMdr, expOut;
	logic expCon;
	logic checking;
	int errors;
	int checks;
	int cycles;
	logic [31:0] lcgState;
	busDatapathPkg::wordT addrList [8];

	busDatapath dut (.clk(clk), .rstN(rstN), .busSel(busSel), .loadEn(loadEn),
		.regLoad(regLoad), .aluOp(aluOp), .gra(gra), .grb(grb), .grc(grc), .rin(rin),
		.rout(rout), .baOut(baOut), .mdRead(mdRead), .readRam(readRam),
		.writeRam(writeRam), .inPortData(inPortData), .bus(bus), .outPort(outPort),
		.conFlag(conFlag), .pc(pc), .ir(ir), .mdr(mdr));

	initial clk = 1'b0;
	always #2 clk = ~clk;

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic busDatapathPkg::loadEnT ldMask(int pos);
		return busDatapathPkg::loadEnT'(1) << pos;
	endfunction

	// expected 64-bit Z value for Y op bus
	function automatic logic [63:0] aluRef(busDatapathPkg::aluOpT op,
		busDatapathPkg::wordT a, busDatapathPkg::wordT b);
		logic [31:0] r;
		longint p;
		int n;
		n = int'(b[4:0]);
		r = a;
		case (op)
			busDatapathPkg::aluAdd: r = a + b;
			busDatapathPkg::aluSub: r = a - b;
			busDatapathPkg::aluAnd: r = a & b;
			busDatapathPkg::aluOr: r = a | b;
			busDatapathPkg::aluShr: r = a >> n;
			busDatapathPkg::aluShra: repeat (n) r = {r[31], r[31:1]};
			busDatapathPkg::aluShl: r = a << n;
			busDatapathPkg::aluRor: repeat (n) r = {r[0], r[31:1]};
			busDatapathPkg::aluRol: repeat (n) r = {r[30:0], r[31]};
			busDatapathPkg::aluMul: begin
				p = longint'($signed(a)) * longint'($signed(b)); // full signed product
				return p;
			end
			busDatapathPkg::aluNeg: r = ~b + 32'd1;
			busDatapathPkg::aluNot: r = ~b;
			busDatapathPkg::aluIncPc: r = b + 32'd1;
			default: r = '0;
		endcase
		return {{32{r[31]}}, r};
	endfunction

	function automatic logic condRef(logic [1:0] c2, busDatapathPkg::wordT b);
		case (c2)
			2'd0: return b == 32'd0;
			2'd1: return b != 32'd0;
			2'd2: return $signed(b) >= 0; // sign bit clear
			default: return $signed(b) < 0;
		endcase
	endfunction

	function automatic busDatapathPkg::regIndexT modelIndex();
		if (gra) return mIr[26:23];
		if (grb) return mIr[22:19];
		if (grc) return mIr[18:15];
		return 4'd0;
	endfunction

	function automatic busDatapathPkg::wordT modelBus();
		busDatapathPkg::regIndexT idx;
		int src;
		idx = modelIndex();
		src = -1;
		if (rout || baOut) return (baOut && idx == 4'd0) ? 32'd0 : mRegs[idx];
		for (int k = 0; k < busDatapathPkg::busSrcCount; k++) begin
			if (busSel == (busDatapathPkg::busSelT'(1) << k)) src = k;
		end
		if (src < 0) return 32'd0; // nothing driving
		if (src < 16) return mRegs[src[3:0]];
		case (src)
			busDatapathPkg::busSrcHi: return mHi;
			busDatapathPkg::busSrcLo: return mLo;
			busDatapathPkg::busSrcZHigh: return mZ[63:32];
			busDatapathPkg::busSrcZLow: return mZ[31:0];
			busDatapathPkg::busSrcPc: return mPc;
			busDatapathPkg::busSrcMdr: return mMdr;
			busDatapathPkg::busSrcInPort: return mInPort;
			default: return {{13{mIr[18]}}, mIr[18:0]}; // constant field
		endcase
	endfunction

	task automatic resetModel();
		for (int i = 0; i < 16; i++) mRegs[i[3:0]] = '0;
		mHi = '0;
		mLo = '0;
		mPc = '0;
		mIr = '0;
		mY = '0;
		mMdr = '0;
		mInPort = '0;
		mOutPort = '0;
		mZ = '0;
		mMar = '0;
		mCon = 1'b0;
	endtask

	task automatic beginStep();
		@(posedge clk);
		#0.5;
		busSel = '0;
		loadEn = '0;
		regLoad = '0;
		aluOp = busDatapathPkg::aluAdd;
		{gra, grb, grc, rin, rout, baOut} = '0;
		{mdRead, readRam, writeRam} = '0;
	endtask

	// predicts this step's bus, then applies its edge to the model
	task automatic endStep();
		busDatapathPkg::wordT b;
		busDatapathPkg::wordT newMdr;
		b = modelBus();
		expBus = b;
		expPc = mPc;
		expIr = mIr;
		expMdr = mMdr;
		expOut = mOutPort;
		expCon = mCon;
		checking = 1'b1;
		newMdr = mMdr;
		if (loadEn[busDatapathPkg::ldMdr]) begin
			if (!mdRead) newMdr = b;
			else if (readRam) newMdr = mRam[mMar]; // MAR from an earlier step
		end
		if (writeRam) mRam[mMar] = mMdr;
		mMdr = newMdr;
		for (int i = 0; i < 16; i++) begin
			if (regLoad[i[3:0]]) mRegs[i[3:0]] = b;
		end
		if (rin) mRegs[modelIndex()] = b;
		if (loadEn[busDatapathPkg::ldZ]) mZ = aluRef(aluOp, mY, b);
		if (loadEn[busDatapathPkg::ldCon]) mCon = condRef(mIr[20:19], b);
		if (loadEn[busDatapathPkg::ldHi]) mHi = b;
		if (loadEn[busDatapathPkg::ldLo]) mLo = b;
		if (loadEn[busDatapathPkg::ldPc]) mPc = b;
		if (loadEn[busDatapathPkg::ldIr]) mIr = b;
		if (loadEn[busDatapathPkg::ldY]) mY = b;
		if (loadEn[busDatapathPkg::ldMar]) mMar = b[8:0];
		if (loadEn[busDatapathPkg::ldOutPort]) mOutPort = b;
		if (loadEn[busDatapathPkg::ldInPort]) mInPort = inPortData;
	endtask

	task automatic busTransfer(int src, busDatapathPkg::loadEnT ld, logic [15:0] direct);
		beginStep();
		if (src >= 0) busSel = busDatapathPkg::busSelT'(1) << src;
		loadEn = ld;
		regLoad = direct;
		endStep();
	endtask

	task automatic portInput(busDatapathPkg::wordT v);
		beginStep();
		inPortData = v;
		loadEn = ldMask(busDatapathPkg::ldInPort);
		endStep();
	endtask

	task automatic loadFromPort(busDatapathPkg::wordT v, busDatapathPkg::loadEnT ld,
		logic [15:0] direct);
		portInput(v);
		busTransfer(busDatapathPkg::busSrcInPort, ld, direct);
	endtask

	task automatic aluStep(int src, busDatapathPkg::aluOpT op);
		beginStep();
		busSel = busDatapathPkg::busSelT'(1) << src;
		aluOp = op;
		loadEn = ldMask(busDatapathPkg::ldZ);
		endStep();
	endtask

	task automatic memWrite();
		beginStep();
		writeRam = 1'b1;
		endStep();
	endtask

	task automatic memRead();
		beginStep();
		mdRead = 1'b1;
		readRam = 1'b1;
		loadEn = ldMask(busDatapathPkg::ldMdr);
		endStep();
	endtask

	// field 0/1/2 picks ra/rb/rc of IR
	task automatic grTransfer(int field, logic wr, logic rd, logic ba,
		busDatapathPkg::loadEnT ld, int src);
		beginStep();
		gra = (field == 0);
		grb = (field == 1);
		grc = (field == 2);
		rin = wr;
		rout = rd;
		baOut = ba;
		loadEn = ld;
		if (src >= 0) busSel = busDatapathPkg::busSelT'(1) << src;
		endStep();
	endtask

	task automatic fetchSequence();
		beginStep();
		busSel = busDatapathPkg::busSelT'(1) << busDatapathPkg::busSrcPc;
		loadEn = ldMask(busDatapathPkg::ldMar) | ldMask(busDatapathPkg::ldZ);
		aluOp = busDatapathPkg::aluIncPc;
		endStep();
		beginStep();
		busSel = busDatapathPkg::busSelT'(1) << busDatapathPkg::busSrcZLow;
		loadEn = ldMask(busDatapathPkg::ldPc) | ldMask(busDatapathPkg::ldMdr);
		mdRead = 1'b1;
		readRam = 1'b1;
		endStep();
		busTransfer(busDatapathPkg::busSrcMdr, ldMask(busDatapathPkg::ldIr), '0);
	endtask

	task automatic checkValue(string name, busDatapathPkg::wordT actual,
		busDatapathPkg::wordT expected);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("** Error at %0.1f ns: %s = %h, expected %h", $realtime, name, actual,
				expected);
		end
	endtask

	always @(negedge clk) begin
		if (checking) begin
			checkValue("bus", bus, expBus);
			checkValue("pc", pc, expPc);
			checkValue("ir", ir, expIr);
			checkValue("mdr", mdr, expMdr);
			checkValue("outPort", outPort, expOut);
			checkValue("conFlag", {31'd0, conFlag}, {31'd0, expCon});
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("timeout: run did not finish within %0d cycles", cycleLimit);
			$display("checks: %0d, errors: %0d", checks, errors);
			$display("test failed");
			$finish;
		end
	end

	initial begin
		busDatapathPkg::wordT a;
		busDatapathPkg::wordT b;
		busDatapathPkg::wordT fetchAddr;
		lcgState = 32'h8204_7156;
		errors = 0;
		checks = 0;
		cycles = 0;
		checking = 1'b0;
		rstN = 1'b0;
		busSel = '0;
		loadEn = '0;
		regLoad = '0;
		aluOp = busDatapathPkg::aluAdd;
		{gra, grb, grc, rin, rout, baOut} = '0;
		{mdRead, readRam, writeRam} = '0;
		inPortData = '0;
		resetModel();
		repeat (8) @(posedge clk);
		#0.5;
		rstN = 1'b1;

		for (int s = 0; s < busDatapathPkg::busSrcCount; s++) busTransfer(s, '0, '0);

		for (int r = 1; r < 16; r++) loadFromPort(nextRand(), '0, 16'd1 << r);
		for (int r = 1; r < 16; r++) busTransfer(r, '0, '0);
		loadFromPort(nextRand(), ldMask(busDatapathPkg::ldHi), '0);
		loadFromPort(nextRand(), ldMask(busDatapathPkg::ldLo), '0);
		busTransfer(busDatapathPkg::busSrcHi, '0, '0);
		busTransfer(busDatapathPkg::busSrcLo, '0, '0);
		loadFromPort({5'd0, 4'd3, 4'd7, 4'd12, 15'h2a5c}, ldMask(busDatapathPkg::ldIr), '0);
		grTransfer(1, 1'b0, 1'b1, 1'b0, ldMask(busDatapathPkg::ldMdr), -1); // rb to MDR
		grTransfer(0, 1'b1, 1'b0, 1'b0, '0, busDatapathPkg::busSrcMdr); // then into ra
		busTransfer(3, '0, '0);
		grTransfer(2, 1'b0, 1'b1, 1'b0, '0, -1);
		grTransfer(2, 1'b1, 1'b0, 1'b0, '0, busDatapathPkg::busSrcC);
		busTransfer(12, '0, '0);
		grTransfer(0, 1'b0, 1'b0, 1'b1, '0, -1); // BAout, ra = 3
		loadFromPort({5'd0, 4'd0, 4'd5, 4'd9, 15'h1234}, ldMask(busDatapathPkg::ldIr), '0);
		loadFromPort(nextRand() | 32'd1, '0, 16'd1); // r0 nonzero so BAout has to mask it
		grTransfer(0, 1'b0, 1'b1, 1'b0, '0, -1); // Rout still sees r0
		grTransfer(0, 1'b0, 1'b0, 1'b1, '0, -1); // ra = 0 reads zero
		grTransfer(1, 1'b0, 1'b1, 1'b0, '0, -1);

		for (int k = 0; k <= 12; k++) begin
			repeat (3) begin
				a = nextRand();
				b = nextRand();
				loadFromPort(a, ldMask(busDatapathPkg::ldY), '0);
				portInput(b);
				aluStep(busDatapathPkg::busSrcInPort, busDatapathPkg::aluOpT'(k));
				busTransfer(busDatapathPkg::busSrcZLow, '0, '0);
				busTransfer(busDatapathPkg::busSrcZHigh, '0, '0);
			end
		end

		for (int k = 0; k < 8; k++) begin
			a = nextRand();
			addrList[k[2:0]] = {23'd0, a[8:0]};
			loadFromPort(addrList[k[2:0]], ldMask(busDatapathPkg::ldMar), '0);
			loadFromPort(nextRand(), ldMask(busDatapathPkg::ldMdr), '0);
			memWrite();
		end
		for (int k = 0; k < 8; k++) begin
			loadFromPort(addrList[k[2:0]], ldMask(busDatapathPkg::ldMar), '0);
			memRead();
			busTransfer(busDatapathPkg::busSrcMdr, '0, '0);
		end
		a = nextRand();
		fetchAddr = {23'd0, a[8:0]};
		loadFromPort(fetchAddr, ldMask(busDatapathPkg::ldMar), '0);
		loadFromPort(nextRand(), ldMask(busDatapathPkg::ldMdr), '0);
		memWrite();
		loadFromPort(fetchAddr, ldMask(busDatapathPkg::ldPc), '0);
		fetchSequence();

		for (int c = 0; c < 4; c++) begin
			loadFromPort({11'd0, 2'(c), 19'd0}, ldMask(busDatapathPkg::ldIr), '0);
			loadFromPort(32'd0, ldMask(busDatapathPkg::ldCon), '0);
			loadFromPort(nextRand() | 32'h8000_0000, ldMask(busDatapathPkg::ldCon), '0);
			loadFromPort(nextRand() & 32'h7fff_ffff, ldMask(busDatapathPkg::ldCon), '0);
			loadFromPort(nextRand(), ldMask(busDatapathPkg::ldCon), '0);
		end
		loadFromPort(nextRand(), ldMask(busDatapathPkg::ldOutPort), '0);
		busTransfer(-1, '0, '0); // lets the last register updates be compared
		@(posedge clk);
		checking = 1'b0;
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end
endmodule
